// ==== logic/tone_pkg.sv ====
package tone_pkg;

	typedef logic [3:0]  note_code_t;	// 0 rest, 1..9 b3 d4 e4 f#4 g4 a4 b4 c5 d5
	typedef logic [19:0] note_div_t;	// half period in clk cycles, 0 silent
	typedef logic [5:0]  letter_t;	// 0..25 a..z, 26 blank

	localparam int         note_count   = 10;	// rest plus nine notes
	localparam note_code_t note_rest    = 4'd0;
	localparam letter_t    letter_blank = 6'd26;	// shown as a space

	////////////////////////////////////////////////////////////////////////////
	// half periods, clk assumed at 25 MHz
	localparam note_div_t note_div_table [0:note_count-1] = '{
		20'd0,	// rest
		20'd50619,	// b3, ~247 Hz
		20'd42566,	// d4
		20'd37921,	// e4
		20'd33784,	// f#4
		20'd31888,	// g4
		20'd28409,	// a4, 440 Hz
		20'd25310,	// b4
		20'd23889,	// c5
		20'd21282	// d5
	};

	////////////////////////////////////////////////////////////////////////////
	// solfege spelling, first and second letter
	localparam letter_t letter1_table [0:note_count-1] = '{
		letter_blank,	// rest
		6'd18,	// s
		6'd17,	// r
		6'd12,	// m
		6'd5,	// f
		6'd18,	// s
		6'd11,	// l
		6'd18,	// s
		6'd3,	// d
		6'd17	// r
	};

	localparam letter_t letter2_table [0:note_count-1] = '{
		letter_blank,
		6'd8, 6'd4, 6'd8,	// i e i
		6'd0, 6'd14, 6'd0,	// a o a
		6'd8, 6'd14, 6'd4	// i o e
	};

endpackage

// ==== logic/score_pkg.sv ====
package score_pkg;

	typedef logic [5:0] duration_t;	// beats per entry, 2 or more
	typedef logic [9:0] score_entry_t;	// {duration, note code}
	typedef logic [2:0] score_addr_t;	// entry index

	localparam int song_length = 8;

	// field extraction, keeps the packing in one place
	function automatic duration_t entry_duration(score_entry_t e);
		return e[9:4];
	endfunction

	function automatic tone_pkg::note_code_t entry_note(score_entry_t e);
		return e[3:0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// the song, played in a loop
	// last beat of every entry is a rest
	localparam score_entry_t song [0:song_length-1] = '{
		{6'd3, 4'd5},	// g4  so
		{6'd2, 4'd3},	// e4  mi
		{6'd3, 4'd6},	// a4  la
		{6'd2, 4'd4},	// f#4 fa
		{6'd3, 4'd2},	// d4  re
		{6'd2, 4'd7},	// b4  si
		{6'd3, 4'd8},	// c5  do
		{6'd4, 4'd9}	// d5  re, long ending
	};

endpackage

// ==== logic/beat_timer.sv ====
`timescale 1ns/1ps

module beat_timer #(
	parameter int beat_cycles = 65536	// clk cycles per beat, sets tempo
) (
	input  logic clk,
	input  logic rst_n,
	input  logic play,	// counting runs only while high
	output logic beat	// one-cycle strobe at the end of each beat
);

	localparam int cnt_w = (beat_cycles > 1) ? $clog2(beat_cycles) : 1;
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(beat_cycles - 1);

	logic [cnt_w-1:0] cnt;	// cycles into the current beat

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt  <= '0;
			beat <= 1'b0;
		end
		else if (play)
		begin
			beat <= (cnt == cnt_last);	// registered, lands beat_cycles after start
			if (cnt == cnt_last)
				cnt <= '0;	// wrap
			else
				cnt <= cnt + 1'b1;
		end
		else
			beat <= 1'b0;	// paused, cnt holds its place
	end

endmodule

// ==== logic/score_rom.sv ====
`timescale 1ns/1ps

module score_rom import score_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         carry,	// move on to the next entry
	output score_entry_t entry	// current entry, combinational
);

	localparam score_addr_t addr_last = score_addr_t'(song_length - 1);

	score_addr_t addr;	// entry being played

	////////////////////////////////////////////////////////////////////////////
	// address counter

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			addr <= '0;
		else if (carry)
		begin
			if (addr == addr_last)
				addr <= '0;	// song loops
			else
				addr <= addr + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// lookup

	// new entry is visible the cycle after carry
	assign entry = song[addr];

endmodule

// ==== logic/note_ctl.sv ====
`timescale 1ns/1ps

module note_ctl import tone_pkg::*, score_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         play,	// low silences at once
	input  logic         beat,	// one-cycle beat strobe
	input  score_entry_t entry,	// from score_rom
	output logic         carry,	// one cycle, advances score_rom
	output note_div_t    note_div,	// half period for tone_gen
	output letter_t      letter1,	// solfege first letter
	output letter_t      letter2	// solfege second letter
);

	typedef enum logic {
		st_tone,	// note sounds
		st_gap	// last beat of the entry, rest
	} state_t;

	state_t     state;
	state_t     state_nxt;
	duration_t  idx;	// beat index within the entry
	duration_t  idx_nxt;
	duration_t  dur;	// beats in this entry
	note_code_t note;	// note code of this entry
	logic       last_beat;	// beat that closes index d-1
	note_code_t code_nxt;	// what sounds from the next edge on

	assign dur  = entry_duration(entry);
	assign note = entry_note(entry);

	assign last_beat = beat && (idx == dur - 6'd1);

	////////////////////////////////////////////////////////////////////////////
	// beat index and state

	always_comb
	begin
		state_nxt = state;
		idx_nxt   = idx;
		if (last_beat)
		begin
			idx_nxt   = '0;	// back to index 0 for the next entry
			state_nxt = st_tone;
		end
		else if (beat)
		begin
			idx_nxt   = idx + 6'd1;
			// rest on index d-1 only
			state_nxt = (idx_nxt == dur - 6'd1) ? st_gap : st_tone;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// effective note

	// entry still holds the old note while carry is in flight, so the
	// hand-over cycles stay silent until score_rom has moved on
	always_comb
	begin
		if (!play || state_nxt == st_gap)
			code_nxt = note_rest;
		else if (last_beat || carry)
			code_nxt = note_rest;	// 2-cycle hand-over
		else if (note >= note_count)
			code_nxt = note_rest;	// unknown code plays as rest
		else
			code_nxt = note;
	end

	////////////////////////////////////////////////////////////////////////////
	// registers, outputs move together with the state

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= st_tone;
			idx      <= '0;
			carry    <= 1'b0;
			note_div <= '0;	// rest values
			letter1  <= letter_blank;
			letter2  <= letter_blank;
		end
		else
		begin
			state    <= state_nxt;
			idx      <= idx_nxt;
			carry    <= last_beat;	// high for one cycle only
			note_div <= note_div_table[code_nxt];
			letter1  <= letter1_table[code_nxt];
			letter2  <= letter2_table[code_nxt];
		end
	end

endmodule

// ==== logic/tone_gen.sv ====
`timescale 1ns/1ps

module tone_gen import tone_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      play,
	input  note_div_t note_div,	// half period, 0 is silence
	output logic      audio	// square wave out
);

	note_div_t cnt;	// cycles into the current half period
	note_div_t prev_div;	// divider seen on the last edge
	logic      wave;	// square wave flop
	logic      silent;	// nothing to play

	assign silent = !play || (note_div == '0);

	////////////////////////////////////////////////////////////////////////////
	// half period counter

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt      <= '0;
			prev_div <= '0;
			wave     <= 1'b0;
		end
		else
		begin
			prev_div <= note_div;
			if (silent || note_div != prev_div)
			begin
				cnt  <= '0;	// restart, wave starts low
				wave <= 1'b0;
			end
			else if (cnt == note_div - 1'b1)
			begin
				cnt  <= '0;
				wave <= ~wave;	// toggle every note_div cycles
			end
			else
				cnt <= cnt + 1'b1;
		end
	end

	// low right away while silent, no wait for the flop
	assign audio = wave && !silent;

endmodule

// ==== logic/music_box_top.sv ====
`timescale 1ns/1ps

module music_box_top import tone_pkg::*, score_pkg::*; #(
	parameter int beat_cycles = 65536	// tempo, clk cycles per beat
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    play,	// low freezes the song
	output logic    audio,	// square wave
	output letter_t letter1,	// solfege name, blank on rest
	output letter_t letter2
);

	logic         beat;	// beat strobe
	logic         carry;	// entry done
	score_entry_t entry;	// current score entry
	note_div_t    note_div;	// half period of the current note

	////////////////////////////////////////////////////////////////////////////
	// timing and score

	beat_timer #(
		.beat_cycles (beat_cycles)
	) u_beat_timer (
		.clk   (clk),
		.rst_n (rst_n),
		.play  (play),
		.beat  (beat)
	);

	score_rom u_score_rom (
		.clk   (clk),
		.rst_n (rst_n),
		.carry (carry),
		.entry (entry)
	);

	////////////////////////////////////////////////////////////////////////////
	// note decision and sound

	note_ctl u_note_ctl (
		.clk      (clk),
		.rst_n    (rst_n),
		.play     (play),
		.beat     (beat),
		.entry    (entry),
		.carry    (carry),
		.note_div (note_div),
		.letter1  (letter1),
		.letter2  (letter2)
	);

	tone_gen u_tone_gen (
		.clk      (clk),
		.rst_n    (rst_n),
		.play     (play),
		.note_div (note_div),
		.audio    (audio)
	);

endmodule

// ==== dv/music_box_asserts.sv ====
`timescale 1ns/1ps

module music_box_asserts import tone_pkg::*; (
	input logic      clk,
	input logic      rst_n,
	input logic      beat,	// tied low where not seen
	input logic      gap,	// resting on the last beat of an entry
	input logic      carry,
	input note_div_t note_div,
	input logic      audio
);

	////////////////////////////////////////////////////////////////////////////
	// carry strobe

	a_carry_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		carry |=> !carry
	) else $error("carry high for more than one cycle");

	// carry only on the beat that closes the rest
	a_carry_on_beat: assert property (
		@(posedge clk) disable iff (!rst_n)
		carry |-> $past(beat && gap)
	) else $error("carry without a beat in the rest before it");

	////////////////////////////////////////////////////////////////////////////
	// silence

	// quiet while note_div is 0 and on the first cycle after it
	a_audio_quiet: assert property (
		@(posedge clk) disable iff (!rst_n)
		((note_div == '0) || $past(note_div == '0)) |-> !audio
	) else $error("audio high while note_div is 0 or just after");

endmodule

bind note_ctl music_box_asserts u_ctl_asserts (
	.clk      (clk),
	.rst_n    (rst_n),
	.beat     (beat),
	.gap      (state == st_gap),
	.carry    (carry),
	.note_div (note_div),
	.audio    (1'b0)	// no audio here
);

bind tone_gen music_box_asserts u_gen_asserts (
	.clk      (clk),
	.rst_n    (rst_n),
	.beat     (1'b0),
	.gap      (1'b0),
	.carry    (1'b0),
	.note_div (note_div),
	.audio    (audio)
);

// ==== dv/music_box_tb.sv ====
`timescale 1ns/1ps

module music_box_tb import tone_pkg::*; ();

	localparam int beat_cycles = 65536;	// one beat covers a half period of b3

	logic    clk;
	logic    rst_n;
	logic    play;
	logic    audio;
	letter_t letter1;
	letter_t letter2;

	int case_kind[$];	// 0 note line, 1 pause line
	int case_l1[$];
	int case_l2[$];
	int case_half[$];	// half period in clk cycles
	bit rest_expected;	// a full rest comes before the next tone
	int seed_ret;

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns
	end

	music_box_top #(
		.beat_cycles (beat_cycles)
	) uut (
		.clk     (clk),
		.rst_n   (rst_n),
		.play    (play),
		.audio   (audio),
		.letter1 (letter1),
		.letter2 (letter2)
	);

	////////////////////////////////////////////////////////////////////////////
	// helpers

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string field, input int actual, input int expected);
		if (actual != expected)
		begin
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, field, actual,
				expected);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic bit letters_blank();
		return (letter1 == letter_blank) && (letter2 == letter_blank);
	endfunction

	task automatic read_cases();
		int                 fd;
		int                 n;
		int                 kind;
		int                 l1;
		int                 l2;
		int                 half;
		logic [8*128-1:0]   line;
		fd = $fopen("dv/music_box_cases.txt", "r");
		if (fd == 0)
			fail_now("could not open dv/music_box_cases.txt");
		while (!$feof(fd))
		begin
			line = '0;
			n = $fgets(line, fd);
			n = $sscanf(line, "%d %d %d %d", kind, l1, l2, half);
			if (n == 4)	// header and empty lines give fewer fields
			begin
				case_kind.push_back(kind);
				case_l1.push_back(l1);
				case_l2.push_back(l2);
				case_half.push_back(half);
			end
		end
		$fclose(fd);
		if (case_kind.size() == 0)
			fail_now("the cases file holds no note or pause lines");
	endtask

	// silence check, one sample per cycle
	task automatic hold_quiet(input int cycles, input string phase);
		repeat (cycles)
		begin
			@(negedge clk);
			check_value({phase, " audio"}, audio, 0);
			check_value({phase, " letter1"}, letter1, letter_blank);
			check_value({phase, " letter2"}, letter2, letter_blank);
		end
	endtask

	// rest before a note, ends on the first tone sample
	task automatic wait_for_tone();
		int blank_cnt;
		blank_cnt = 0;
		while (letters_blank())
		begin
			check_value("audio during rest", audio, 0);
			@(negedge clk);
			blank_cnt++;
			if (blank_cnt > 2 * beat_cycles + 16)
				fail_now("timeout: the next note never started");
		end
		if (rest_expected)	// last beat of an entry plus hand-over
			check_value("rest lasts a beat", int'(blank_cnt >= beat_cycles), 1);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// one note line and one pause line

	task automatic play_note(input int idx);
		int   l1;
		int   l2;
		int   half;
		int   cnt;
		logic last_audio;
		l1   = case_l1[idx];
		l2   = case_l2[idx];
		half = case_half[idx];
		wait_for_tone();
		check_value("letter1", letter1, l1);
		check_value("letter2", letter2, l2);
		// divider lands with the letters, tone_gen restarts one edge later
		cnt = 0;
		while (!audio)
		begin
			@(negedge clk);
			cnt++;
			if (letters_blank())
				fail_now("note ended before its first audio toggle");
			if (cnt > beat_cycles)
				fail_now("timeout: the first audio toggle never came");
		end
		check_value("first half period", cnt, half + 1);
		cnt        = 0;
		last_audio = audio;
		while (!letters_blank())
		begin
			@(negedge clk);
			cnt++;
			if (!letters_blank())
			begin
				if (letter1 != l1 || letter2 != l2)	// letters hold through the tone
				begin
					check_value("letter1 in tone", letter1, l1);
					check_value("letter2 in tone", letter2, l2);
				end
				if (audio != last_audio)
				begin
					check_value("half period", cnt, half);
					cnt        = 0;
					last_audio = audio;
				end
			end
			if (cnt > beat_cycles)
				fail_now("timeout: the tone never ended or stopped toggling");
		end
		rest_expected = 1'b1;
	endtask

	task automatic pause_song(input int idx);
		int hold;
		int cnt;
		int l1;
		int l2;
		if (idx + 1 >= case_kind.size() || case_kind[idx + 1] != 0)
			fail_now("a pause line is not followed by a note line");
		l1 = case_l1[idx + 1];	// entry that gets paused
		l2 = case_l2[idx + 1];
		wait_for_tone();
		check_value("letter1 before pause", letter1, l1);
		check_value("letter2 before pause", letter2, l2);
		repeat (200) @(negedge clk);	// well inside the tone
		@(posedge clk);
		play <= 1'b0;
		hold = 200 + ($urandom % 1800);
		@(negedge clk);
		check_value("audio as play drops", audio, 0);	// letters follow one edge later
		hold_quiet(hold, "pause");
		@(posedge clk);
		play <= 1'b1;
		@(negedge clk);
		cnt = 0;
		while (letters_blank())
		begin
			@(negedge clk);
			cnt++;
			if (cnt > 16)
				fail_now("timeout: the song did not resume after the pause");
		end
		check_value("letter1 after pause", letter1, l1);	// same entry again
		check_value("letter2 after pause", letter2, l2);
		rest_expected = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence

	initial
	begin
		rst_n         = 1'b0;
		play          = 1'b0;
		rest_expected = 1'b0;
		seed_ret      = $urandom(27);
		read_cases();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		hold_quiet(300, "idle");	// play still low
		@(posedge clk);
		play <= 1'b1;
		@(negedge clk);
		for (int i = 0; i < case_kind.size(); i++)
		begin
			if (case_kind[i] == 1)
				pause_song(i);
			else
				play_note(i);
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== dv/music_box_cases.txt ====
# columns: kind letter1 letter2 half_period, kind 0 is a note line, kind 1 a pause line
# letters are codes 0..25 for a..z, half period in clock cycles, pause pauses the next entry
0 18 14 31888   so g4
0 12 8  37921   mi e4
1 0  0  0       pause
0 11 0  28409   la a4
0 5  0  33784   fa f#4
0 17 4  42566   re d4
0 18 8  25310   si b4
0 3  14 23889   do c5
0 17 4  21282   re d5
0 18 14 31888   so g4 after the wrap
1 0  0  0       pause
0 12 8  37921   mi e4
0 11 0  28409   la a4

// ==== sources.f ====
logic/tone_pkg.sv
logic/score_pkg.sv
logic/beat_timer.sv
logic/score_rom.sv
logic/note_ctl.sv
logic/tone_gen.sv
logic/music_box_top.sv
dv/music_box_asserts.sv
dv/music_box_tb.sv
